// File: bench/chip8_checker.sv
`timescale 1ns/1ps

module chip8_checker (
   input  logic                    clk,
   input  logic                    rst_n,
   input  chip8_bus_pkg::apb_req_t apb_req,
   input  chip8_bus_pkg::apb_rsp_t apb_rsp,
   input  logic                    check_en,
   input  logic                    exp_err,
   input  logic [31:0]             exp_data,
   input  logic                    test_end,
   input  string                   test_name,
   output int                      pass_total,
   output int                      fail_total
);

   int    test_pass;
   int    test_fail;
   string label;

   function automatic string reg_name(input logic [15:0] addr);
      if (addr == chip8_bus_pkg::CTRL_ADDR)
         return "CTRL";
      if (addr == chip8_bus_pkg::STATUS_ADDR)
         return "STATUS";
      if (addr == chip8_bus_pkg::IREG_ADDR)
         return "I";
      if (addr == chip8_bus_pkg::PC_ADDR)
         return "PC";
      if (addr >= chip8_bus_pkg::VREG_BASE && addr < chip8_bus_pkg::IREG_ADDR)
         return $sformatf("V%0h", addr[5:2]);
      if (addr < chip8_bus_pkg::CTRL_ADDR)
         return $sformatf("mem[0x%03h]", addr[11:0]);
      return $sformatf("0x%04h", addr);
   endfunction

   always @(posedge clk)
   begin
      if (!rst_n)
      begin
         pass_total = 0;
         fail_total = 0;
         test_pass  = 0;
         test_fail  = 0;
      end
      else
      begin
         // access phase with an expectation attached
         if (apb_req.psel && apb_req.penable && check_en)
         begin
            label = reg_name(apb_req.paddr);
            if (apb_rsp.pready !== 1'b1)
            begin
               $display("FAIL %t %s pready: got %0b, expected 1",
                        $realtime, label, apb_rsp.pready);
               test_fail++;
            end
            else if (apb_rsp.pslverr !== exp_err)
            begin
               $display("FAIL %t %s pslverr: got %0b, expected %0b",
                        $realtime, label, apb_rsp.pslverr, exp_err);
               test_fail++;
            end
            else if (!apb_req.pwrite && !exp_err && apb_rsp.prdata !== exp_data)
            begin
               $display("FAIL %t %s: got 0x%0h, expected 0x%0h",
                        $realtime, label, apb_rsp.prdata, exp_data);
               test_fail++;
            end
            else
               test_pass++;
         end
         if (test_end)
         begin
            $display("test %s: %0d checks passed, %0d failed", test_name, test_pass, test_fail);
            pass_total = pass_total + test_pass;
            fail_total = fail_total + test_fail;
            test_pass  = 0;
            test_fail  = 0;
         end
      end
   end

endmodule

// File: bench/chip8_stimulus.txt
# records: T name | L addr count opcodes | W addr data | E addr data (write, pslverr)
# G run to halt | P wait for halt | R addr expected | X addr (read, pslverr) | D end
T reg_ops
L 200 8 60C8 6164 8200 8214 83F0 8410 8405 85F0
L 210 8 8610 8607 87F0 8810 8806 89F0 8A00 8A0E
L 220 7 8BF0 8C00 8C11 8C02 8C13 7050 00FD
G
R 1040 18 R 1044 64 R 1048 2C R 104C 01 R 1050 9C R 1054 00 R 1058 64
R 105C 01 R 1060 32 R 1064 00 R 1068 90 R 106C 01 R 1070 AC R 107C 01
D
T skip_jump
L 200 8 6E00 6A05 6B05 3A05 6EEE 4A05 6211 5AB0
L 210 8 6EEE 9AB0 6422 4A06 6EEE 9A20 6EEE 1222
L 220 8 6EEE 6004 B228 6EEE 6EEE 6EEE 6733 00FD
G
R 1078 00 R 1048 11 R 1050 22 R 1040 04 R 105C 33 R 1084 22E
D
T call_ret
L 200 3 2300 6111 00FD
L 300 4 6233 2400 6344 00EE
L 400 2 6455 00EE
G
R 1044 11 R 1048 33 R 104C 44 R 1050 55 R 1084 204
D
T mem_ops
L 200 7 A300 6310 F31E 6AFE FA33 F265 00FD
G
R 1040 02 R 1044 05 R 1048 04 R 1080 310 R 1084 20C
D
T host_err
L 200 5 6010 70FF 3000 1202 00FD
W 1000 1 E 0300 AA E 1000 1
P
R 1004 2 R 1040 00 R 1084 208 X 1010 X 2000 E 1004 1
D

// File: bench/tb_chip8.sv
`timescale 1ns/1ps

module tb_chip8;

   localparam int    CLK_HALF          = 2;
   localparam int    RESET_CYCLES      = 16;
   localparam int    CYCLES_PER_RECORD = 2000;
   localparam string STIM_FILE         = "bench/chip8_stimulus.txt";

   logic                    clk;
   logic                    rst_n;
   chip8_bus_pkg::apb_req_t apb_req;
   chip8_bus_pkg::apb_rsp_t apb_rsp;
   logic                    check_en;
   logic                    exp_err;
   logic [31:0]             exp_data;
   logic                    test_end;
   string                   test_name;
   int                      pass_total;
   int                      fail_total;
   int                      bad_records;
   logic                    loaded;

   // one entry per stimulus record with program loads split into bytes
   string       cmd_q[$];
   logic [15:0] addr_q[$];
   logic [31:0] data_q[$];
   string       name_q[$];

   chip8_top u_dut (
      .clk,
      .rst_n,
      .apb_req,
      .apb_rsp
   );

   chip8_checker u_checker (
      .clk, .rst_n, .apb_req, .apb_rsp, .check_en, .exp_err, .exp_data,
      .test_end, .test_name, .pass_total, .fail_total
   );

   always #CLK_HALF clk = ~clk;

   task automatic add_record(input string cmd, input logic [15:0] addr,
                             input logic [31:0] data, input string name);
      cmd_q.push_back(cmd);
      addr_q.push_back(addr);
      data_q.push_back(data);
      name_q.push_back(name);
   endtask

   task automatic load_stimulus();
      int          fd;
      int          code;
      int          count;
      string       tok;
      string       line;
      logic [15:0] addr;
      logic [31:0] data;
      logic [15:0] op;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0)
      begin
         $display("cannot open stimulus file %s", STIM_FILE);
         bad_records++;
         return;
      end
      while ($fscanf(fd, "%s", tok) == 1)
      begin
         addr = '0;
         data = '0;
         case (tok)
            "#": code = $fgets(line, fd); // comment to end of line
            "T":
            begin
               code = $fscanf(fd, "%s", line);
               add_record(tok, addr, data, line);
            end
            "L":
            begin
               code = $fscanf(fd, "%h %d", addr, count);
               for (int k = 0; k < count; k++)
               begin
                  code = $fscanf(fd, "%h", op);
                  add_record("W", addr, {24'd0, op[15:8]}, "");
                  add_record("W", addr + 16'd1, {24'd0, op[7:0]}, "");
                  addr = addr + 16'd2;
               end
            end
            "W", "E", "R":
            begin
               code = $fscanf(fd, "%h %h", addr, data);
               add_record(tok, addr, data, "");
            end
            "X":
            begin
               code = $fscanf(fd, "%h", addr);
               add_record(tok, addr, data, "");
            end
            default: add_record(tok, addr, data, "");
         endcase
      end
      $fclose(fd);
   endtask

   task automatic apb_transfer(input logic wr, input logic [15:0] addr,
                               input logic [31:0] wdata, input logic chk,
                               input logic err, input logic [31:0] exp,
                               output logic [31:0] rdata);
      @(posedge clk);
      apb_req  <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
      check_en <= chk;
      exp_err  <= err;
      exp_data <= exp;
      @(posedge clk);
      apb_req.penable <= 1'b1;
      do
         @(negedge clk);
      while (!apb_rsp.pready);
      rdata = apb_rsp.prdata;
      @(posedge clk); // transfer completes here
      apb_req  <= '0;
      check_en <= 1'b0;
   endtask

   task automatic wait_halted();
      logic [31:0] status;
      status = '0;
      while (!status[1])
         apb_transfer(1'b0, chip8_bus_pkg::STATUS_ADDR, '0, 1'b0, 1'b0, '0, status);
   endtask

   task automatic finish_test();
      @(posedge clk);
      test_end <= 1'b1;
      @(posedge clk);
      test_end <= 1'b0;
   endtask

   initial
   begin
      logic [31:0] rdata;
      int          tests;
      $timeformat(-9, 1, " ns", 10);
      clk       = 1'b0;
      rst_n     = 1'b0;
      apb_req   = '0;
      check_en  = 1'b0;
      exp_err   = 1'b0;
      exp_data  = '0;
      test_end  = 1'b0;
      test_name = "";
      bad_records = 0;
      tests       = 0;
      loaded      = 1'b0;
      load_stimulus();
      loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < cmd_q.size(); i++)
      begin
         case (cmd_q[i])
            "T": test_name = name_q[i];
            "W": apb_transfer(1'b1, addr_q[i], data_q[i], 1'b1, 1'b0, '0, rdata);
            "E": apb_transfer(1'b1, addr_q[i], data_q[i], 1'b1, 1'b1, '0, rdata);
            "R": apb_transfer(1'b0, addr_q[i], '0, 1'b1, 1'b0, data_q[i], rdata);
            "X": apb_transfer(1'b0, addr_q[i], '0, 1'b1, 1'b1, '0, rdata);
            "G":
            begin
               apb_transfer(1'b1, chip8_bus_pkg::CTRL_ADDR, 32'd1, 1'b1, 1'b0, '0, rdata);
               wait_halted();
            end
            "P": wait_halted();
            "D":
            begin
               finish_test();
               tests++;
            end
            default:
            begin
               $display("unknown stimulus record %s", cmd_q[i]);
               bad_records++;
            end
         endcase
      end
      repeat (2) @(posedge clk);
      $display("%0d tests, %0d checks passed, %0d failed, %0d bad records",
               tests, pass_total, fail_total, bad_records);
      if (fail_total == 0 && bad_records == 0 && pass_total > 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   // limit scales with the number of stimulus records
   initial
   begin
      int limit;
      wait (loaded === 1'b1);
      limit = (cmd_q.size() + 1) * CYCLES_PER_RECORD;
      repeat (limit) @(posedge clk);
      $display("run timed out after %0d cycles", limit);
      $display("Result: FAILED");
      $finish;
   end

endmodule

// File: common/chip8_bus_pkg.sv
package chip8_bus_pkg;

   typedef logic [15:0] apb_addr_t;
   typedef logic [31:0] apb_data_t;

   typedef struct packed {
      logic      psel;
      logic      penable;
      logic      pwrite;
      apb_addr_t paddr;
      apb_data_t pwdata;
   } apb_req_t;

   typedef struct packed {
      logic      pready;
      apb_data_t prdata;
      logic      pslverr;
   } apb_rsp_t;

   // program memory sits below CTRL_ADDR
   localparam apb_addr_t CTRL_ADDR   = 16'h1000;
   localparam apb_addr_t STATUS_ADDR = 16'h1004;
   localparam apb_addr_t VREG_BASE   = 16'h1040;
   localparam apb_addr_t IREG_ADDR   = 16'h1080;
   localparam apb_addr_t PC_ADDR     = 16'h1084;

endpackage

// File: common/chip8_isa_pkg.sv
package chip8_isa_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [11:0] addr_t;
   typedef logic [3:0]  vidx_t;
   typedef logic [15:0] ireg_t;

   localparam int    MEM_BYTES     = 4096;
   localparam addr_t PROGRAM_START = 12'h200;
   localparam int    STACK_DEPTH   = 16;
   localparam int    SP_WIDTH      = $clog2(STACK_DEPTH);
   localparam vidx_t FLAG_REG      = 4'hf;

   // 0NNN forms, matched on NNN
   localparam addr_t SYS_RET  = 12'h0ee;
   localparam addr_t SYS_HALT = 12'h0fd;

   // FX__ forms, matched on KK
   localparam byte_t FX_ADD_I = 8'h1e;
   localparam byte_t FX_BCD   = 8'h33;
   localparam byte_t FX_LOAD  = 8'h65;

   typedef enum logic [3:0] {
      OP_SYS, OP_JP, OP_CALL, OP_SE_BYTE,
      OP_SNE_BYTE, OP_SE_REG, OP_LD_BYTE, OP_ADD_BYTE,
      OP_ALU, OP_SNE_REG, OP_LD_I, OP_JP_V0,
      OP_RND, OP_DRW, OP_SKP, OP_MISC
   } op_group_e;

   typedef enum logic [3:0] {
      ALU_LD   = 4'h0,
      ALU_OR   = 4'h1,
      ALU_AND  = 4'h2,
      ALU_XOR  = 4'h3,
      ALU_ADD  = 4'h4,
      ALU_SUB  = 4'h5,
      ALU_SHR  = 4'h6,
      ALU_SUBN = 4'h7,
      ALU_SHL  = 4'he
   } alu_op_e;

   typedef enum logic [2:0] {
      IDLE, FETCH_HI, FETCH_LO, EXEC, WAIT_EXEC, HALTED
   } fetch_state_e;

   typedef struct packed {
      op_group_e  op;
      vidx_t      x;
      vidx_t      y;
      logic [3:0] n;
      byte_t      kk;
      addr_t      nnn;
   } instr_t;

endpackage

// File: core/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  exec_valid,
   input  chip8_isa_pkg::instr_t instr,
   input  chip8_isa_pkg::byte_t  rd_data,
   input  chip8_isa_pkg::vidx_t  v_dbg_idx,
   output logic                  exec_done,
   output logic                  skip,
   output chip8_isa_pkg::byte_t  v0,
   output logic                  exec_rd_en,
   output chip8_isa_pkg::addr_t  exec_rd_addr,
   output logic                  exec_wr_en,
   output chip8_isa_pkg::addr_t  exec_wr_addr,
   output chip8_isa_pkg::byte_t  exec_wr_data,
   output chip8_isa_pkg::ireg_t  i_reg,
   output chip8_isa_pkg::byte_t  v_dbg_data
);

   chip8_isa_pkg::byte_t   v [16];
   chip8_isa_pkg::ireg_t   i_q;
   chip8_isa_pkg::addr_t   i_addr;
   chip8_isa_pkg::byte_t   vx;
   chip8_isa_pkg::byte_t   vy;
   chip8_isa_pkg::byte_t   alu_res;
   chip8_isa_pkg::alu_op_e alu_op;
   logic                   alu_flag;
   logic                   flag_q;
   logic                   flag_op;
   logic                   is_bcd;
   logic                   is_load;
   logic                   active;
   logic [4:0]             step;
   logic [4:0]             last;

   assign vx      = v[instr.x];
   assign vy      = v[instr.y];
   assign v0      = v[0];
   assign i_reg   = i_q;
   assign i_addr  = i_q[11:0];
   assign alu_op  = chip8_isa_pkg::alu_op_e'(instr.n);
   assign is_bcd  = instr.op == chip8_isa_pkg::OP_MISC && instr.kk == chip8_isa_pkg::FX_BCD;
   assign is_load = instr.op == chip8_isa_pkg::OP_MISC && instr.kk == chip8_isa_pkg::FX_LOAD;
   assign flag_op = instr.op == chip8_isa_pkg::OP_ALU && alu_op inside {
      chip8_isa_pkg::ALU_ADD, chip8_isa_pkg::ALU_SUB, chip8_isa_pkg::ALU_SHR,
      chip8_isa_pkg::ALU_SUBN, chip8_isa_pkg::ALU_SHL};

   assign v_dbg_data = v[v_dbg_idx];

   always_comb
   begin
      alu_res  = vx;
      alu_flag = 1'b0;
      case (alu_op)
         chip8_isa_pkg::ALU_LD:   alu_res = vy;
         chip8_isa_pkg::ALU_OR:   alu_res = vx | vy;
         chip8_isa_pkg::ALU_AND:  alu_res = vx & vy;
         chip8_isa_pkg::ALU_XOR:  alu_res = vx ^ vy;
         chip8_isa_pkg::ALU_ADD:  {alu_flag, alu_res} = vx + vy;
         chip8_isa_pkg::ALU_SUB:
         begin
            alu_res  = vx - vy;
            alu_flag = vx > vy;
         end
         chip8_isa_pkg::ALU_SUBN:
         begin
            alu_res  = vy - vx;
            alu_flag = vy > vx;
         end
         chip8_isa_pkg::ALU_SHR:
         begin
            alu_res  = vx >> 1;
            alu_flag = vx[0];
         end
         chip8_isa_pkg::ALU_SHL:
         begin
            alu_res  = vx << 1;
            alu_flag = vx[7];
         end
         default: ;
      endcase
   end

   always_comb
   begin
      case (instr.op)
         chip8_isa_pkg::OP_SE_BYTE:  skip = vx == instr.kk;
         chip8_isa_pkg::OP_SNE_BYTE: skip = vx != instr.kk;
         chip8_isa_pkg::OP_SE_REG:   skip = vx == vy;
         chip8_isa_pkg::OP_SNE_REG:  skip = vx != vy;
         default:                    skip = 1'b0;
      endcase
   end

   // last step of the running instruction, step 0 is the exec_valid cycle
   always_comb
   begin
      if (is_load)
         last = {1'b0, instr.x} + 5'd1;
      else if (is_bcd)
         last = 5'd3;
      else if (flag_op)
         last = 5'd1;
      else
         last = 5'd0;
   end

   assign active    = exec_valid || step != 5'd0;
   assign exec_done = active && step == last;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         step <= '0;
      else if (exec_done)
         step <= '0;
      else if (active)
         step <= step + 5'd1;
   end

   // FX65 reads one byte ahead of the register write
   assign exec_rd_en   = active && is_load && step <= {1'b0, instr.x};
   assign exec_rd_addr = i_addr + chip8_isa_pkg::addr_t'(step);

   assign exec_wr_en   = active && is_bcd && step != 5'd0;
   assign exec_wr_addr = i_addr + chip8_isa_pkg::addr_t'(step) - 12'd1;

   always_comb
   begin
      case (step)
         5'd1:    exec_wr_data = vx / 8'd100; // hundreds
         5'd2:    exec_wr_data = (vx / 8'd10) % 8'd10;
         default: exec_wr_data = vx % 8'd10;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (exec_valid)
      begin
         case (instr.op)
            chip8_isa_pkg::OP_LD_BYTE:  v[instr.x] <= instr.kk;
            chip8_isa_pkg::OP_ADD_BYTE: v[instr.x] <= vx + instr.kk; // no carry
            chip8_isa_pkg::OP_ALU:      v[instr.x] <= alu_res;
            chip8_isa_pkg::OP_LD_I:     i_q <= {4'h0, instr.nnn};
            chip8_isa_pkg::OP_MISC:
               if (instr.kk == chip8_isa_pkg::FX_ADD_I)
                  i_q <= i_q + {8'h00, vx};
            default: ;
         endcase
         flag_q <= alu_flag;
      end
      else if (flag_op && step == 5'd1)
         v[chip8_isa_pkg::FLAG_REG] <= {7'd0, flag_q}; // after the result
      if (is_load && step != 5'd0)
         v[step[3:0] - 4'd1] <= rd_data;
   end

   a_done_bound: assert property (@(posedge clk) disable iff (!rst_n)
      exec_valid |-> ##[0:17] exec_done);

endmodule

// File: core/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start,
   input  chip8_isa_pkg::byte_t  rd_data,
   input  logic                  exec_done,
   input  logic                  skip,
   input  chip8_isa_pkg::byte_t  v0,
   output chip8_isa_pkg::addr_t  fetch_addr,
   output chip8_isa_pkg::instr_t instr,
   output logic                  exec_valid,
   output chip8_isa_pkg::addr_t  pc,
   output logic                  running,
   output logic                  halted
);

   chip8_isa_pkg::fetch_state_e state;
   chip8_isa_pkg::addr_t        stack [chip8_isa_pkg::STACK_DEPTH];
   logic [chip8_isa_pkg::SP_WIDTH:0]   sp;
   logic [chip8_isa_pkg::SP_WIDTH-1:0] top_idx;
   chip8_isa_pkg::byte_t        hi_q;
   chip8_isa_pkg::instr_t       dec;
   logic                        is_call;
   logic                        is_ret;
   logic                        is_halt;

   // low byte arrives in EXEC
   assign dec = '{
      op:  chip8_isa_pkg::op_group_e'(hi_q[7:4]),
      x:   hi_q[3:0],
      y:   rd_data[7:4],
      n:   rd_data[3:0],
      kk:  rd_data,
      nnn: {hi_q[3:0], rd_data}
   };

   assign is_call = dec.op == chip8_isa_pkg::OP_CALL;
   assign is_ret  = dec.op == chip8_isa_pkg::OP_SYS && dec.nnn == chip8_isa_pkg::SYS_RET;
   assign is_halt = dec.op == chip8_isa_pkg::OP_SYS && dec.nnn == chip8_isa_pkg::SYS_HALT;
   assign top_idx = sp[chip8_isa_pkg::SP_WIDTH-1:0] - 1'b1;

   assign fetch_addr = (state == chip8_isa_pkg::FETCH_LO) ? pc + 12'd1 : pc;
   assign halted     = state == chip8_isa_pkg::HALTED;
   assign running    = state != chip8_isa_pkg::IDLE && !halted;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state      <= chip8_isa_pkg::IDLE;
         pc         <= chip8_isa_pkg::PROGRAM_START;
         sp         <= '0;
         exec_valid <= 1'b0;
      end
      else
      begin
         exec_valid <= 1'b0;
         case (state)
            chip8_isa_pkg::IDLE, chip8_isa_pkg::HALTED:
               if (start)
               begin
                  state <= chip8_isa_pkg::FETCH_HI;
                  pc    <= chip8_isa_pkg::PROGRAM_START;
                  sp    <= '0;
               end
            chip8_isa_pkg::FETCH_HI:
               state <= chip8_isa_pkg::FETCH_LO;
            chip8_isa_pkg::FETCH_LO:
               state <= chip8_isa_pkg::EXEC;
            chip8_isa_pkg::EXEC:
               if (is_halt)
                  state <= chip8_isa_pkg::HALTED; // pc left on the halt
               else
               begin
                  state      <= chip8_isa_pkg::WAIT_EXEC;
                  exec_valid <= 1'b1;
                  if (is_ret)
                  begin
                     pc <= stack[top_idx];
                     sp <= sp - 1'b1;
                  end
                  else if (is_call)
                  begin
                     pc <= dec.nnn;
                     sp <= sp + 1'b1;
                  end
                  else if (dec.op == chip8_isa_pkg::OP_JP)
                     pc <= dec.nnn;
                  else if (dec.op == chip8_isa_pkg::OP_JP_V0)
                     pc <= dec.nnn + {4'h0, v0};
                  else
                     pc <= pc + 12'd2;
               end
            chip8_isa_pkg::WAIT_EXEC:
               if (exec_done)
               begin
                  state <= chip8_isa_pkg::FETCH_HI;
                  if (skip)
                     pc <= pc + 12'd2;
               end
            default:
               state <= chip8_isa_pkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == chip8_isa_pkg::FETCH_LO)
         hi_q <= rd_data;
      if (state == chip8_isa_pkg::EXEC)
         instr <= dec;
      if (state == chip8_isa_pkg::EXEC && is_call)
         stack[sp[chip8_isa_pkg::SP_WIDTH-1:0]] <= pc + 12'd2; // return address
   end

   a_stack_bounds: assert property (@(posedge clk) disable iff (!rst_n)
      state == chip8_isa_pkg::EXEC |->
         !(is_ret && sp == '0) && !(is_call && sp == chip8_isa_pkg::STACK_DEPTH));

endmodule

// File: hw/chip8_top.sv
`timescale 1ns/1ps

module chip8_top (
   input  logic                    clk,
   input  logic                    rst_n,
   input  chip8_bus_pkg::apb_req_t apb_req,
   output chip8_bus_pkg::apb_rsp_t apb_rsp
);

   logic                  start;
   logic                  host_wr_en;
   chip8_isa_pkg::addr_t  host_wr_addr;
   chip8_isa_pkg::byte_t  host_wr_data;
   chip8_isa_pkg::vidx_t  v_dbg_idx;
   chip8_isa_pkg::byte_t  v_dbg_data;
   chip8_isa_pkg::ireg_t  i_reg;
   chip8_isa_pkg::addr_t  pc;
   logic                  running;
   logic                  halted;
   chip8_isa_pkg::addr_t  fetch_addr;
   chip8_isa_pkg::byte_t  rd_data;
   chip8_isa_pkg::instr_t instr;
   logic                  exec_valid;
   logic                  exec_done;
   logic                  skip;
   chip8_isa_pkg::byte_t  v0;
   logic                  exec_rd_en;
   chip8_isa_pkg::addr_t  exec_rd_addr;
   logic                  exec_wr_en;
   chip8_isa_pkg::addr_t  exec_wr_addr;
   chip8_isa_pkg::byte_t  exec_wr_data;

   host_apb_port u_host (
      .clk, .rst_n, .apb_req, .pc, .halted, .running, .v_dbg_data, .i_reg,
      .apb_rsp, .start, .host_wr_en, .host_wr_addr, .host_wr_data, .v_dbg_idx
   );

   program_memory u_mem (
      .clk, .fetch_addr, .exec_rd_en, .exec_rd_addr,
      .host_wr_en, .host_wr_addr, .host_wr_data,
      .exec_wr_en, .exec_wr_addr, .exec_wr_data,
      .rd_data
   );

   fetch_sequencer u_fetch (
      .clk, .rst_n, .start, .rd_data, .exec_done, .skip, .v0,
      .fetch_addr, .instr, .exec_valid, .pc, .running, .halted
   );

   execute_unit u_exec (
      .clk, .rst_n, .exec_valid, .instr, .rd_data, .v_dbg_idx,
      .exec_done, .skip, .v0, .exec_rd_en, .exec_rd_addr,
      .exec_wr_en, .exec_wr_addr, .exec_wr_data, .i_reg, .v_dbg_data
   );

endmodule

// File: hw/host_apb_port.sv
`timescale 1ns/1ps

module host_apb_port (
   input  logic                    clk,
   input  logic                    rst_n,
   input  chip8_bus_pkg::apb_req_t apb_req,
   input  chip8_isa_pkg::addr_t    pc,
   input  logic                    halted,
   input  logic                    running,
   input  chip8_isa_pkg::byte_t    v_dbg_data,
   input  chip8_isa_pkg::ireg_t    i_reg,
   output chip8_bus_pkg::apb_rsp_t apb_rsp,
   output logic                    start,
   output logic                    host_wr_en,
   output chip8_isa_pkg::addr_t    host_wr_addr,
   output chip8_isa_pkg::byte_t    host_wr_data,
   output chip8_isa_pkg::vidx_t    v_dbg_idx
);

   chip8_bus_pkg::apb_addr_t addr;
   chip8_bus_pkg::apb_data_t rd_mux;
   chip8_bus_pkg::apb_data_t prdata_q;
   logic setup;
   logic access;
   logic mem_sel;
   logic ctrl_sel;
   logic status_sel;
   logic vreg_sel;
   logic ireg_sel;
   logic pc_sel;
   logic mapped;
   logic err;
   logic err_q;

   assign addr   = apb_req.paddr;
   assign setup  = apb_req.psel && !apb_req.penable;
   assign access = apb_req.psel && apb_req.penable;

   assign mem_sel    = addr < chip8_bus_pkg::CTRL_ADDR;
   assign ctrl_sel   = addr == chip8_bus_pkg::CTRL_ADDR;
   assign status_sel = addr == chip8_bus_pkg::STATUS_ADDR;
   assign vreg_sel   = addr[15:6] == chip8_bus_pkg::VREG_BASE[15:6] && addr[1:0] == 2'b00;
   assign ireg_sel   = addr == chip8_bus_pkg::IREG_ADDR;
   assign pc_sel     = addr == chip8_bus_pkg::PC_ADDR;
   assign mapped     = mem_sel || ctrl_sel || status_sel || vreg_sel || ireg_sel || pc_sel;

   // only memory and CTRL take writes, and only while stopped
   assign err = !mapped || (apb_req.pwrite && (running || !(mem_sel || ctrl_sel)));

   assign v_dbg_idx = addr[5:2];

   always_comb
   begin
      rd_mux = '0;
      if (status_sel)
         rd_mux = {30'd0, halted, running};
      else if (vreg_sel)
         rd_mux = {24'd0, v_dbg_data};
      else if (ireg_sel)
         rd_mux = {16'd0, i_reg};
      else if (pc_sel)
         rd_mux = {20'd0, pc};
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         err_q <= 1'b0;
      else if (setup)
         err_q <= err;
   end

   always_ff @(posedge clk)
   begin
      if (setup)
         prdata_q <= rd_mux; // held through access
   end

   assign host_wr_en   = access && apb_req.pwrite && mem_sel && !err_q;
   assign host_wr_addr = addr[11:0];
   assign host_wr_data = apb_req.pwdata[7:0];
   assign start        = access && apb_req.pwrite && ctrl_sel && apb_req.pwdata[0] && !err_q;

   assign apb_rsp = '{pready: 1'b1, prdata: prdata_q, pslverr: access && err_q};

   // prdata and pslverr were captured for this address in setup
   a_access_follows_setup: assert property (@(posedge clk) disable iff (!rst_n)
      access |-> $past(setup) && $stable(apb_req.paddr));

endmodule

// File: hw/program_memory.sv
`timescale 1ns/1ps

module program_memory (
   input  logic                 clk,
   input  chip8_isa_pkg::addr_t fetch_addr,
   input  logic                 exec_rd_en,
   input  chip8_isa_pkg::addr_t exec_rd_addr,
   input  logic                 host_wr_en,
   input  chip8_isa_pkg::addr_t host_wr_addr,
   input  chip8_isa_pkg::byte_t host_wr_data,
   input  logic                 exec_wr_en,
   input  chip8_isa_pkg::addr_t exec_wr_addr,
   input  chip8_isa_pkg::byte_t exec_wr_data,
   output chip8_isa_pkg::byte_t rd_data
);

   chip8_isa_pkg::byte_t mem [chip8_isa_pkg::MEM_BYTES];
   chip8_isa_pkg::addr_t rd_addr;
   chip8_isa_pkg::addr_t wr_addr;
   chip8_isa_pkg::byte_t wr_data;
   logic                 wr_en;

   assign rd_addr = exec_rd_en ? exec_rd_addr : fetch_addr; // execute wins
   assign wr_en   = host_wr_en || exec_wr_en;
   assign wr_addr = exec_wr_en ? exec_wr_addr : host_wr_addr;
   assign wr_data = exec_wr_en ? exec_wr_data : host_wr_data;

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
      rd_data <= mem[rd_addr];
   end

   a_one_writer: assert property (@(posedge clk) !(host_wr_en && exec_wr_en));

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the CHIP-8 testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_chip8 -o tb_chip8_sim
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

output="$(./obj_dir/tb_chip8_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qxF "Result: PASSED"; then
   exit 0
fi
exit 1

// File: src.f
common/chip8_isa_pkg.sv
common/chip8_bus_pkg.sv
hw/host_apb_port.sv
hw/program_memory.sv
core/fetch_sequencer.sv
core/execute_unit.sv
hw/chip8_top.sv
bench/chip8_checker.sv
bench/tb_chip8.sv
